/* stm_pkg.sv */
/* Package for the gain STM engine: array geometry, memory widths,
   trigger period and the operator state and gain mode enums. */

package stm_pkg;

  // Array geometry and pulse width.
  localparam int num_trans       = 249;
  localparam int pw_width        = 13;
  localparam int trans_idx_width = 8;

  // Gain memory. A read address is {base[2:0], offset[5:0]}.
  localparam int gain_data_width = 128;
  localparam int gain_addr_width = 9;
  localparam int wr_addr_width   = 12; // Read address plus a 3-bit lane select.
  localparam int mem_latency     = 2;

  // STM sequencing.
  localparam int idx_width   = 4;
  localparam int trig_period = 320; // Must exceed one frame of num_trans pairs.

  typedef enum logic [1:0] {
    waiting,
    bram_wait_0,
    bram_wait_1,
    run
  } op_state_t;

  // Encoding of a stored pattern.
  typedef enum logic {
    mode_normal = 1'b0,
    mode_legacy = 1'b1
  } gain_mode_t;

endpackage

/* stm_gain_memory.sv */
/* Gain pattern memory: 16-bit lane writes from the host and
   pipelined 128-bit reads for the gain operator. */

`timescale 1ns/1ps

module stm_gain_memory (
  input  logic                                CLK_L,
  input  logic                                wr_en,
  input  logic [stm_pkg::wr_addr_width-1:0]   wr_addr,
  input  logic [15:0]                         wr_data,
  input  logic [stm_pkg::gain_addr_width-1:0] gain_addr,
  output logic [stm_pkg::gain_data_width-1:0] gain_data
);

  logic [stm_pkg::gain_data_width-1:0] mem [2**stm_pkg::gain_addr_width];

  // Address stages ahead of the output register.
  logic [stm_pkg::gain_addr_width-1:0] addr_q [stm_pkg::mem_latency-1];

  logic [stm_pkg::gain_addr_width-1:0] wr_word;
  logic [2:0]                          wr_lane;

  assign wr_word = wr_addr[stm_pkg::wr_addr_width-1:3];
  assign wr_lane = wr_addr[2:0];

  // Host side. Each write replaces one 16-bit slice of a word.
  always_ff @(posedge CLK_L) begin
    if (wr_en) begin
      mem[wr_word][{wr_lane, 4'h0} +: 16] <= wr_data;
    end
  end

  // Read side behaves as a block RAM with an output register.
  always_ff @(posedge CLK_L) begin
    addr_q[0] <= gain_addr;
    for (int i = 1; i < stm_pkg::mem_latency - 1; i++) begin
      addr_q[i] <= addr_q[i-1];
    end
    gain_data <= mem[addr_q[stm_pkg::mem_latency-2]];
  end

endmodule

/* stm_index_timer.sv */
/* Index timer: periodic trigger and STM index stepping by
   frequency divider and cycle length. */

`timescale 1ns/1ps

module stm_index_timer (
  input  logic                          CLK_L,
  input  logic                          arst_n,
  input  logic                          enable,
  input  logic [15:0]                   freq_div,
  input  logic [stm_pkg::idx_width:0]   cycle_len,
  output logic                          trig,
  output logic [stm_pkg::idx_width-1:0] idx
);

  logic [$clog2(stm_pkg::trig_period)-1:0] period_cnt;
  logic [15:0]                             trig_cnt;

  always_ff @(posedge CLK_L or negedge arst_n) begin
    if (!arst_n) begin
      period_cnt <= '0;
      trig       <= 1'b0;
    end else if (!enable) begin
      period_cnt <= '0;
      trig       <= 1'b0;
    end else if (period_cnt == stm_pkg::trig_period - 1) begin
      period_cnt <= '0;
      trig       <= 1'b1;
    end else begin
      period_cnt <= period_cnt + 1'b1;
      trig       <= 1'b0;
    end
  end

  // Step idx only after the operator has sampled it with trig.
  always_ff @(posedge CLK_L or negedge arst_n) begin
    if (!arst_n) begin
      trig_cnt <= '0;
      idx      <= '0;
    end else if (trig) begin
      if (trig_cnt + 16'd1 >= freq_div) begin
        trig_cnt <= '0;
        if ({1'b0, idx} + 1'b1 >= cycle_len) begin
          idx <= '0; // Wrap at the end of the sequence.
        end else begin
          idx <= idx + 1'b1;
        end
      end else begin
        trig_cnt <= trig_cnt + 16'd1;
      end
    end
  end

  a_trig_single: assert property (@(posedge CLK_L) disable iff (!arst_n)
    trig |=> !trig)
    else $error("trig high on two consecutive cycles");

endmodule

/* stm_gain_operator.sv */
/* Gain operator: per-trigger pattern fetch and duty/phase streaming
   in legacy (8-bit) or normal (16-bit) format. */

`timescale 1ns/1ps

module stm_gain_operator (
  input  logic                                CLK_L,
  input  logic                                arst_n,
  input  logic                                trig,
  input  logic [stm_pkg::idx_width-1:0]       idx,
  input  stm_pkg::gain_mode_t                 gain_mode,
  output logic [stm_pkg::gain_addr_width-1:0] gain_addr,
  input  logic [stm_pkg::gain_data_width-1:0] gain_data,
  output logic [stm_pkg::pw_width-1:0]        duty,
  output logic [stm_pkg::pw_width-1:0]        phase,
  output logic                                dout_valid
);

  stm_pkg::op_state_t state;

  logic [2:0] addr_base;
  logic [5:0] addr_offset;
  logic [2:0] set_cnt; // Pair slot within the current word.
  logic [$clog2(stm_pkg::num_trans)-1:0] cnt;

  logic       legacy;
  logic       offset_step;

  logic [stm_pkg::pw_width-1:0] leg_phase;
  logic [stm_pkg::pw_width-1:0] leg_duty;
  logic [stm_pkg::pw_width-1:0] nrm_phase;
  logic [stm_pkg::pw_width-1:0] nrm_duty;

  assign legacy    = (gain_mode == stm_pkg::mode_legacy);
  assign gain_addr = {addr_base, addr_offset};

  // Legacy: eight {duty, phase} byte pairs per word, expanded to 13 bits.
  assign leg_phase = {1'b0, gain_data[{set_cnt, 4'h0} +: 8], 4'h0};
  assign leg_duty  = {2'b00, gain_data[{set_cnt, 4'h8} +: 8], 3'h7} + 13'd1;

  // Normal: four {duty, phase} 16-bit pairs per word, low 13 bits kept.
  assign nrm_phase = gain_data[{set_cnt[1:0], 5'd0} +: stm_pkg::pw_width];
  assign nrm_duty  = gain_data[{set_cnt[1:0], 5'd16} +: stm_pkg::pw_width];

  // Request the next word early so it lands exactly at slot 0.
  assign offset_step = legacy ? (set_cnt == 3'd5) : (set_cnt[1:0] == 2'd1);

  always_ff @(posedge CLK_L or negedge arst_n) begin
    if (!arst_n) begin
      state       <= stm_pkg::waiting;
      dout_valid  <= 1'b0;
      addr_base   <= '0;
      addr_offset <= '0;
      set_cnt     <= '0;
      cnt         <= '0;
    end else begin
      case (state)
        stm_pkg::waiting: begin
          dout_valid <= 1'b0;
          if (trig) begin
            if (legacy) begin
              addr_base   <= idx[3:1];
              addr_offset <= idx[0] ? 6'd32 : 6'd0; // Odd points use the upper half.
            end else begin
              addr_base   <= idx[2:0];
              addr_offset <= '0;
            end
            state <= stm_pkg::bram_wait_0;
          end
        end
        stm_pkg::bram_wait_0: begin
          state <= stm_pkg::bram_wait_1;
        end
        stm_pkg::bram_wait_1: begin
          cnt     <= '0;
          set_cnt <= '0;
          state   <= stm_pkg::run;
        end
        stm_pkg::run: begin
          dout_valid <= 1'b1;
          set_cnt    <= set_cnt + 1'b1;
          if (offset_step) begin
            addr_offset <= addr_offset + 1'b1;
          end
          cnt <= cnt + 1'b1;
          if (cnt == stm_pkg::num_trans - 1) begin
            state <= stm_pkg::waiting;
          end
        end
        default: begin
          state <= stm_pkg::waiting;
        end
      endcase
    end
  end

  always_ff @(posedge CLK_L) begin
    if (state == stm_pkg::run) begin
      if (legacy) begin
        phase <= leg_phase;
        duty  <= leg_duty;
      end else begin
        phase <= nrm_phase;
        duty  <= nrm_duty;
      end
    end
  end

  // The last pair leaves one cycle after run has ended.
  a_valid_in_run: assert property (@(posedge CLK_L) disable iff (!arst_n)
    dout_valid |-> $past(state) == stm_pkg::run)
    else $error("dout_valid outside run");

  a_legacy_duty: assert property (@(posedge CLK_L) disable iff (!arst_n)
    dout_valid && legacy |-> duty <= 13'd2048)
    else $error("legacy duty above 2048");

endmodule

/* stm_drive_output.sv */
/* Drive output stage: registered duty/phase pairs with transducer
   numbering and an end-of-frame pulse. */

`timescale 1ns/1ps

module stm_drive_output (
  input  logic                                CLK_L,
  input  logic                                arst_n,
  input  logic [stm_pkg::pw_width-1:0]        duty,
  input  logic [stm_pkg::pw_width-1:0]        phase,
  input  logic                                dout_valid,
  output logic [stm_pkg::pw_width-1:0]        drv_duty,
  output logic [stm_pkg::pw_width-1:0]        drv_phase,
  output logic                                drv_valid,
  output logic [stm_pkg::trans_idx_width-1:0] trans_idx,
  output logic                                frame_done
);

  logic last_pair;

  // The pair being accepted now is the last one of the frame.
  assign last_pair = drv_valid && (trans_idx == stm_pkg::num_trans - 2);

  always_ff @(posedge CLK_L) begin
    drv_duty  <= duty;
    drv_phase <= phase;
  end

  always_ff @(posedge CLK_L or negedge arst_n) begin
    if (!arst_n) begin
      drv_valid  <= 1'b0;
      trans_idx  <= '0;
      frame_done <= 1'b0;
    end else begin
      drv_valid <= dout_valid;
      if (dout_valid) begin
        trans_idx  <= drv_valid ? trans_idx + 1'b1 : '0; // First pair of a frame is 0.
        frame_done <= last_pair;
      end else begin
        trans_idx  <= '0;
        frame_done <= 1'b0;
      end
    end
  end

  a_trans_idx_range: assert property (@(posedge CLK_L) disable iff (!arst_n)
    drv_valid |-> trans_idx <= stm_pkg::num_trans - 1)
    else $error("trans_idx beyond last transducer");

endmodule

/* stm_top.sv */
/* Top level of the gain STM engine: memory, index timer,
   gain operator and drive output stage. */

`timescale 1ns/1ps

module stm_top (
  input  logic                                CLK_L,
  input  logic                                arst_n,
  input  logic                                wr_en,
  input  logic [stm_pkg::wr_addr_width-1:0]   wr_addr,
  input  logic [15:0]                         wr_data,
  input  logic                                enable,
  input  logic [15:0]                         freq_div,
  input  logic [stm_pkg::idx_width:0]         cycle_len,
  input  stm_pkg::gain_mode_t                 gain_mode,
  output logic [stm_pkg::pw_width-1:0]        drv_duty,
  output logic [stm_pkg::pw_width-1:0]        drv_phase,
  output logic                                drv_valid,
  output logic [stm_pkg::trans_idx_width-1:0] trans_idx,
  output logic                                frame_done
);

  logic                                trig;
  logic [stm_pkg::idx_width-1:0]       idx;
  logic [stm_pkg::gain_addr_width-1:0] gain_addr;
  logic [stm_pkg::gain_data_width-1:0] gain_data;
  logic [stm_pkg::pw_width-1:0]        duty;
  logic [stm_pkg::pw_width-1:0]        phase;
  logic                                dout_valid;

  stm_gain_memory u_gain_memory (
    .CLK_L     (CLK_L),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .gain_addr (gain_addr),
    .gain_data (gain_data)
  );

  stm_index_timer u_index_timer (
    .CLK_L     (CLK_L),
    .arst_n    (arst_n),
    .enable    (enable),
    .freq_div  (freq_div),
    .cycle_len (cycle_len),
    .trig      (trig),
    .idx       (idx)
  );

  stm_gain_operator u_gain_operator (
    .CLK_L      (CLK_L),
    .arst_n     (arst_n),
    .trig       (trig),
    .idx        (idx),
    .gain_mode  (gain_mode),
    .gain_addr  (gain_addr),
    .gain_data  (gain_data),
    .duty       (duty),
    .phase      (phase),
    .dout_valid (dout_valid)
  );

  stm_drive_output u_drive_output (
    .CLK_L      (CLK_L),
    .arst_n     (arst_n),
    .duty       (duty),
    .phase      (phase),
    .dout_valid (dout_valid),
    .drv_duty   (drv_duty),
    .drv_phase  (drv_phase),
    .drv_valid  (drv_valid),
    .trans_idx  (trans_idx),
    .frame_done (frame_done)
  );

endmodule

/* stm_tb_tests.svh */
/* Directed tests: idle outputs, normal and legacy frames,
   index stepping with frame gaps. */

`ifndef STM_TB_TESTS_SVH
`define STM_TB_TESTS_SVH

// Timer off, so no frame may start over several trigger periods.
task automatic test_idle_outputs();
  int err_before;
  err_before = err_cnt;
  apply_reset();
  repeat (3 * stm_pkg::trig_period) begin
    @(negedge CLK_L);
    check_flag("drv_valid", 1'b0, drv_valid);
    check_flag("frame_done", 1'b0, frame_done);
  end
  report_test("idle outputs", err_before);
endtask

task automatic test_normal_frame();
  int err_before;
  int gap;
  err_before = err_cnt;
  apply_reset();
  fill_pattern(stm_pkg::mode_normal, 0);
  gain_mode = stm_pkg::mode_normal;
  freq_div  = 16'd1;
  cycle_len = 5'd1;
  enable    = 1'b1;
  capture_frame(gap);
  check_frame_values(stm_pkg::mode_normal, 0);
  enable = 1'b0;
  report_test("normal frame", err_before);
endtask

task automatic test_legacy_frames();
  int err_before;
  int gap;
  err_before = err_cnt;
  apply_reset();
  fill_pattern(stm_pkg::mode_legacy, 0);
  fill_pattern(stm_pkg::mode_legacy, 1); // Same base, upper half.
  gain_mode = stm_pkg::mode_legacy;
  freq_div  = 16'd1;
  cycle_len = 5'd2;
  enable    = 1'b1;
  for (int p = 0; p < 2; p++) begin
    capture_frame(gap);
    check_frame_values(stm_pkg::mode_legacy, p);
  end
  enable = 1'b0;
  report_test("legacy frames", err_before);
endtask

task automatic test_stepping_and_gaps();
  int err_before;
  int gap;
  int m;
  int exp_p;
  int step_div;
  int seq_len;
  err_before = err_cnt;
  step_div   = 2;
  seq_len    = 3;
  apply_reset();
  for (int p = 0; p < seq_len; p++) begin
    fill_pattern(stm_pkg::mode_normal, p);
  end
  gain_mode = stm_pkg::mode_normal;
  freq_div  = step_div[15:0];
  cycle_len = seq_len[stm_pkg::idx_width:0];
  enable    = 1'b1;
  for (int f = 0; f < 7; f++) begin
    capture_frame(gap);
    exp_p = (f / step_div) % seq_len; // Frame f comes from trigger f.
    m = match_pattern(stm_pkg::mode_normal, seq_len);
    if (m < 0) begin
      $display("Frame %0d matches none of the stored patterns", f);
      err_cnt++;
    end else begin
      check_idx($sformatf("idx of frame %0d", f), exp_p[3:0], m[3:0]);
    end
    if (f > 0 && gap + 1 < stm_pkg::trig_period - stm_pkg::num_trans) begin
      $display("Frame %0d came only %0d idle cycles after the last one", f, gap + 1);
      err_cnt++;
    end
  end
  enable = 1'b0;
  report_test("stepping and gaps", err_before);
endtask

`endif

/* stm_top_tb.sv */
/* Testbench top for the gain STM engine: clock, reset, watchdog, DUT,
   memory shadow, expected pair values and compare tasks. */

`timescale 1ns/1ps

module stm_top_tb;

  localparam int normal_words = (stm_pkg::num_trans + 3) / 4;
  localparam int legacy_words = (stm_pkg::num_trans + 7) / 8;
  localparam int num_frames   = 10; // One normal, two legacy, seven stepping.
  localparam int idle_periods = 6;  // Idle test and the first trigger of each frame test.
  localparam int fill_writes  = 8 * (4 * normal_words + 2 * legacy_words);
  localparam int wd_limit_ns  =
    ((num_frames + idle_periods + 4) * stm_pkg::trig_period + fill_writes) * 4;

  logic                                CLK_L;
  logic                                arst_n;
  logic                                wr_en;
  logic [stm_pkg::wr_addr_width-1:0]   wr_addr;
  logic [15:0]                         wr_data;
  logic                                enable;
  logic [15:0]                         freq_div;
  logic [stm_pkg::idx_width:0]         cycle_len;
  stm_pkg::gain_mode_t                 gain_mode;
  logic [stm_pkg::pw_width-1:0]        drv_duty;
  logic [stm_pkg::pw_width-1:0]        drv_phase;
  logic                                drv_valid;
  logic [stm_pkg::trans_idx_width-1:0] trans_idx;
  logic                                frame_done;

  logic [stm_pkg::gain_data_width-1:0] shadow [2**stm_pkg::gain_addr_width];
  logic [stm_pkg::pw_width-1:0]        cap_duty [stm_pkg::num_trans];
  logic [stm_pkg::pw_width-1:0]        cap_phase [stm_pkg::num_trans];

  integer seed = 32'h05687bf6;
  int     err_cnt = 0;
  int     check_cnt = 0;
  int     test_cnt = 0;

  stm_top UUT (
    .CLK_L      (CLK_L),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .enable     (enable),
    .freq_div   (freq_div),
    .cycle_len  (cycle_len),
    .gain_mode  (gain_mode),
    .drv_duty   (drv_duty),
    .drv_phase  (drv_phase),
    .drv_valid  (drv_valid),
    .trans_idx  (trans_idx),
    .frame_done (frame_done)
  );

  always #2 CLK_L = ~CLK_L;

  task automatic check_pw(input string name, input logic [stm_pkg::pw_width-1:0] exp,
                          input logic [stm_pkg::pw_width-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h got 0x%h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_trans_idx(input string name,
                                 input logic [stm_pkg::trans_idx_width-1:0] exp,
                                 input logic [stm_pkg::trans_idx_width-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h got 0x%h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_idx(input string name, input logic [stm_pkg::idx_width-1:0] exp,
                           input logic [stm_pkg::idx_width-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h got 0x%h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h got 0x%h", name, exp, act);
      err_cnt++;
    end
  endtask

  // Legacy points share a base; odd points use the upper 32 words.
  function automatic int pattern_word(stm_pkg::gain_mode_t mode, int p, int w);
    if (mode == stm_pkg::mode_legacy) begin
      return (p / 2) * 64 + (p % 2) * 32 + w;
    end
    return p * 64 + w;
  endfunction

  function automatic logic [stm_pkg::pw_width-1:0] expected_phase(
    stm_pkg::gain_mode_t mode, int p, int t);
    logic [7:0] b;
    if (mode == stm_pkg::mode_legacy) begin
      b = shadow[pattern_word(mode, p, t / 8)][16 * (t % 8) +: 8];
      return {5'd0, b} * 13'd16;
    end
    return shadow[pattern_word(mode, p, t / 4)][32 * (t % 4) +: stm_pkg::pw_width];
  endfunction

  function automatic logic [stm_pkg::pw_width-1:0] expected_duty(
    stm_pkg::gain_mode_t mode, int p, int t);
    logic [7:0] b;
    if (mode == stm_pkg::mode_legacy) begin
      b = shadow[pattern_word(mode, p, t / 8)][16 * (t % 8) + 8 +: 8];
      return {5'd0, b} * 13'd8 + 13'd8;
    end
    return shadow[pattern_word(mode, p, t / 4)][32 * (t % 4) + 16 +: stm_pkg::pw_width];
  endfunction

  task automatic apply_reset();
    @(negedge CLK_L);
    enable = 1'b0;
    arst_n = 1'b0;
    repeat (3) @(negedge CLK_L);
    arst_n = 1'b1;
  endtask

  task automatic host_write(input logic [stm_pkg::wr_addr_width-1:0] addr,
                            input logic [15:0] data);
    @(negedge CLK_L);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    shadow[addr[stm_pkg::wr_addr_width-1:3]][{addr[2:0], 4'h0} +: 16] = data;
  endtask

  task automatic fill_pattern(input stm_pkg::gain_mode_t mode, input int p);
    int          n_words;
    int          word;
    logic [31:0] rnd;
    n_words = (mode == stm_pkg::mode_legacy) ? legacy_words : normal_words;
    for (int w = 0; w < n_words; w++) begin
      word = pattern_word(mode, p, w);
      for (int lane = 0; lane < 8; lane++) begin
        rnd = $random(seed);
        host_write({word[8:0], lane[2:0]}, rnd[15:0]);
      end
    end
    @(negedge CLK_L);
    wr_en = 1'b0;
  endtask

  // Gap excludes the idle cycle checked after the previous frame.
  task automatic capture_frame(output int gap);
    gap = 0;
    @(negedge CLK_L);
    while (!drv_valid) begin
      check_flag("frame_done between frames", 1'b0, frame_done);
      gap++;
      @(negedge CLK_L);
    end
    for (int t = 0; t < stm_pkg::num_trans; t++) begin
      if (t > 0) begin
        @(negedge CLK_L);
      end
      check_flag($sformatf("drv_valid[%0d]", t), 1'b1, drv_valid);
      check_trans_idx($sformatf("trans_idx[%0d]", t), t[7:0], trans_idx);
      check_flag($sformatf("frame_done[%0d]", t), t == stm_pkg::num_trans - 1, frame_done);
      cap_duty[t]  = drv_duty;
      cap_phase[t] = drv_phase;
    end
    @(negedge CLK_L);
    check_flag("drv_valid after last pair", 1'b0, drv_valid);
    check_flag("frame_done after last pair", 1'b0, frame_done);
  endtask

  task automatic check_frame_values(input stm_pkg::gain_mode_t mode, input int p);
    for (int t = 0; t < stm_pkg::num_trans; t++) begin
      check_pw($sformatf("drv_phase[%0d]", t), expected_phase(mode, p, t), cap_phase[t]);
      check_pw($sformatf("drv_duty[%0d]", t), expected_duty(mode, p, t), cap_duty[t]);
    end
  endtask

  function automatic int match_pattern(stm_pkg::gain_mode_t mode, int n_pat);
    bit same;
    for (int p = 0; p < n_pat; p++) begin
      same = 1'b1;
      for (int t = 0; t < stm_pkg::num_trans; t++) begin
        if (cap_phase[t] !== expected_phase(mode, p, t) ||
            cap_duty[t] !== expected_duty(mode, p, t)) begin
          same = 1'b0;
        end
      end
      if (same) begin
        return p;
      end
    end
    return -1;
  endfunction

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  `include "stm_tb_tests.svh"

  initial begin
    #(wd_limit_ns);
    $display("Timeout: a frame never finished within %0d ns", wd_limit_ns);
    $display("tests failed");
    $finish;
  end

  initial begin
    CLK_L     = 1'b0;
    arst_n    = 1'b0;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    enable    = 1'b0;
    freq_div  = 16'd1;
    cycle_len = 5'd1;
    gain_mode = stm_pkg::mode_normal;
    test_idle_outputs();
    test_normal_frame();
    test_legacy_frames();
    test_stepping_and_gaps();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* stm_top.f */
+incdir+.
stm_pkg.sv
stm_gain_memory.sv
stm_index_timer.sv
stm_gain_operator.sv
stm_drive_output.sv
stm_top.sv
stm_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the STM testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module stm_top_tb -f stm_top.f -o stm_top_sim

./obj_dir/stm_top_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi
